// ==== common/b200_core_settings.svh ====
// control path constants for the b200 core
// stream IDs, demux mask, setting addresses
// compat numbers, magic word and radio count

`ifndef B200_CORE_SETTINGS_SVH
`define B200_CORE_SETTINGS_SVH

// stream IDs, low byte of dst_sid
`define R1_CTRL_SID      8'h20
`define L0_CTRL_SID      8'h40
`define DEMUX_SID_MASK   8'hF0

// settings bus addresses
`define SR_CORE_MISC     8'd16
`define SR_CORE_READBACK 8'd32
`define SR_CORE_GPSDO_ST 8'd40
`define SR_CORE_SYNC     8'd48

// readback identification
`define COMPAT_MAJOR     16'h0010
`define COMPAT_MINOR     16'h0000
`define CORE_MAGIC       32'hACE0BA5E
`define RADIO_STATUS     8'd1

`define CTRL_WIDTH       64

`endif

// ==== common/b200_core_pkg.sv ====
// shared types for the b200 control path
// control word union with header and command views
// readback source select

package b200_core_pkg;

    // first word of every control packet
    typedef struct packed {
        logic [15:0] seqnum;
        logic [15:0] pkt_len;
        logic [15:0] src_sid;
        logic [15:0] dst_sid;
    } ctrl_hdr_t;

    // second word, one settings write
    typedef struct packed {
        logic [23:0] reserved;
        logic [7:0]  set_addr;
        logic [31:0] set_data;
    } ctrl_cmd_t;

    // same 64 bits, read as header or as command
    typedef union packed {
        ctrl_hdr_t hdr;
        ctrl_cmd_t cmd;
    } ctrl_word_u;

    typedef enum logic [1:0] {
        RB_COMPAT = 2'd0,
        RB_SPI    = 2'd1,
        RB_STATUS = 2'd2,
        RB_LOCK   = 2'd3
    } rb_sel_t;

endpackage

// ==== common/cvita_stream_if.sv ====
// valid/ready control stream, one 64 bit word per beat
// source and sink modports

`timescale 1ns/1ns

interface cvita_stream_if;
    import b200_core_pkg::*;

    ctrl_word_u tdata;
    logic       tlast;
    logic       tvalid;
    logic       tready;

    modport source (output tdata, output tlast, output tvalid, input tready);
    modport sink (input tdata, input tlast, input tvalid, output tready);
endinterface

// ==== routing/sid_ctrl_demux.sv ====
// control packet demux
// steers whole packets by masked dst_sid
// to the local processor or the empty slot loopback

`timescale 1ns/1ns
`include "b200_core_settings.svh"

module sid_ctrl_demux (
    input  logic                  bus_clk,
    input  logic                  bus_rst,
    cvita_stream_if.sink          i_ctrl,
    cvita_stream_if.source        o_local,
    cvita_stream_if.source        o_loop
);
    import b200_core_pkg::*;

    ctrl_hdr_t first_hdr;
    logic      hdr_is_loop;
    logic      in_pkt;
    logic      dest_loop_q;
    logic      sel_loop;
    logic      xfer;

    // only meaningful while the first word is on the bus
    assign first_hdr = i_ctrl.tdata.hdr;
    assign hdr_is_loop = ((first_hdr.dst_sid[7:0] & `DEMUX_SID_MASK) == `R1_CTRL_SID);

    // decode on the header, latched value for the rest
    assign sel_loop = in_pkt ? dest_loop_q : hdr_is_loop;
    assign xfer = i_ctrl.tvalid & i_ctrl.tready;

    ////////////////////
    // outputs
    ////////////////////
    assign o_local.tdata  = i_ctrl.tdata;
    assign o_local.tlast  = i_ctrl.tlast;
    assign o_local.tvalid = i_ctrl.tvalid & ~sel_loop;

    assign o_loop.tdata   = i_ctrl.tdata;
    assign o_loop.tlast   = i_ctrl.tlast;
    assign o_loop.tvalid  = i_ctrl.tvalid & sel_loop;

    assign i_ctrl.tready  = sel_loop ? o_loop.tready : o_local.tready;

    // packet tracking
    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            in_pkt      <= 1'b0;
            dest_loop_q <= 1'b0;
        end else if (xfer) begin
            in_pkt <= ~i_ctrl.tlast;
            if (!in_pkt) begin
                dest_loop_q <= hdr_is_loop;
            end
        end
    end
endmodule

// ==== routing/ctrl_resp_mux.sv ====
// response merge of processor and loopback streams
// fixed priority to the processor when idle
// grant held until the granted packet ends

`timescale 1ns/1ns

module ctrl_resp_mux (
    input  logic           bus_clk,
    input  logic           bus_rst,
    cvita_stream_if.sink   i_proc,
    cvita_stream_if.sink   i_loop,
    cvita_stream_if.source o_resp
);
    logic busy;
    logic grant_loop_q;
    logic sel_loop;

    // idle: processor wins a tie
    assign sel_loop = busy ? grant_loop_q : (~i_proc.tvalid & i_loop.tvalid);

    ////////////////////
    // data path
    ////////////////////
    assign o_resp.tdata  = sel_loop ? i_loop.tdata  : i_proc.tdata;
    assign o_resp.tlast  = sel_loop ? i_loop.tlast  : i_proc.tlast;
    assign o_resp.tvalid = sel_loop ? i_loop.tvalid : i_proc.tvalid;

    assign i_proc.tready = ~sel_loop & o_resp.tready;
    assign i_loop.tready = sel_loop & o_resp.tready;

    // lock the grant as soon as a word is offered,
    // so a late processor word cannot pull the bus away
    // from a loopback word that is still waiting
    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            busy         <= 1'b0;
            grant_loop_q <= 1'b0;
        end else if (o_resp.tvalid) begin
            busy <= ~(o_resp.tready & o_resp.tlast);
            if (!busy) begin
                grant_loop_q <= sel_loop;
            end
        end
    end
endmodule

// ==== logic/core_ctrl_proc.sv ====
// core control processor
// header + command in, one settings write,
// two word response with swapped SIDs and readback

`timescale 1ns/1ns
`include "b200_core_settings.svh"

module core_ctrl_proc (
    input  logic                   bus_clk,
    input  logic                   bus_rst,
    cvita_stream_if.sink           i_ctrl,
    cvita_stream_if.source         o_resp,
    output logic                   o_set_stb,
    output logic [7:0]             o_set_addr,
    output logic [31:0]            o_set_data,
    input  logic [`CTRL_WIDTH-1:0] i_readback
);
    import b200_core_pkg::*;

    localparam logic [15:0] RESP_LEN = 16'd16;

    typedef enum logic [2:0] {
        S_HDR,
        S_CMD,
        S_DRAIN,
        S_STB,
        S_RESP_HDR,
        S_RESP_DATA
    } state_t;

    state_t     state;
    ctrl_hdr_t  hdr_q;
    ctrl_cmd_t  cmd_q;
    ctrl_word_u resp_hdr;
    ctrl_word_u rb_q;
    logic       in_xfer;
    logic       out_xfer;

    assign in_xfer  = i_ctrl.tvalid & i_ctrl.tready;
    assign out_xfer = o_resp.tvalid & o_resp.tready;

    ////////////////////
    // state machine
    ////////////////////
    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            state <= S_HDR;
        end else begin
            case (state)
                // header with tlast is dropped
                S_HDR:       if (in_xfer && !i_ctrl.tlast) state <= S_CMD;
                S_CMD:       if (in_xfer) state <= i_ctrl.tlast ? S_STB : S_DRAIN;
                S_DRAIN:     if (in_xfer && i_ctrl.tlast) state <= S_STB;
                S_STB:       state <= S_RESP_HDR;
                S_RESP_HDR:  if (out_xfer) state <= S_RESP_DATA;
                S_RESP_DATA: if (out_xfer) state <= S_HDR;
                default:     state <= S_HDR;
            endcase
        end
    end

    // captured words
    always_ff @(posedge bus_clk) begin
        if (state == S_HDR && in_xfer) begin
            hdr_q <= i_ctrl.tdata.hdr;
        end
        if (state == S_CMD && in_xfer) begin
            cmd_q <= i_ctrl.tdata.cmd;
        end
        // readback after the write, frozen for the data word
        if (state == S_RESP_HDR) begin
            rb_q <= i_readback;
        end
    end

    // response header, src and dst swapped
    always_comb begin
        resp_hdr.hdr.seqnum  = hdr_q.seqnum;
        resp_hdr.hdr.pkt_len = RESP_LEN;
        resp_hdr.hdr.src_sid = hdr_q.dst_sid;
        resp_hdr.hdr.dst_sid = hdr_q.src_sid;
    end

    ////////////////////
    // outputs
    ////////////////////
    assign i_ctrl.tready = (state == S_HDR) || (state == S_CMD) || (state == S_DRAIN);

    assign o_resp.tvalid = (state == S_RESP_HDR) || (state == S_RESP_DATA);
    assign o_resp.tlast  = (state == S_RESP_DATA);
    assign o_resp.tdata  = (state == S_RESP_DATA) ? rb_q : resp_hdr;

    assign o_set_stb  = (state == S_STB);
    assign o_set_addr = cmd_q.set_addr;
    assign o_set_data = cmd_q.set_data;
endmodule

// ==== logic/core_settings.sv ====
// core settings registers
// misc, readback select, gpsdo status, sync
// lock signal double flop and readback mux

`timescale 1ns/1ns
`include "b200_core_settings.svh"

module core_settings (
    input  logic                   bus_clk,
    input  logic                   bus_rst,
    input  logic                   i_set_stb,
    input  logic [7:0]             i_set_addr,
    input  logic [31:0]            i_set_data,
    input  logic [31:0]            i_rb_misc,
    input  logic [1:0]             i_lock_signals,
    output logic [31:0]            o_misc_outs,
    output logic [1:0]             o_pps_select,
    output logic                   o_time_sync,
    output logic [`CTRL_WIDTH-1:0] o_readback
);
    import b200_core_pkg::*;

    logic [31:0] misc_q;
    rb_sel_t     rb_sel;
    logic [7:0]  gpsdo_st;
    logic [2:0]  sync_q;
    logic [1:0]  lock_meta;
    logic [1:0]  lock_sync;

    ////////////////////
    // setting registers
    ////////////////////
    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            misc_q <= 32'd0;
            rb_sel <= RB_COMPAT;
            sync_q <= 3'd0;
        end else if (i_set_stb) begin
            case (i_set_addr)
                `SR_CORE_MISC:     misc_q <= i_set_data;
                `SR_CORE_READBACK: rb_sel <= rb_sel_t'(i_set_data[1:0]);
                `SR_CORE_SYNC:     sync_q <= i_set_data[2:0];
                default:           ;
            endcase
        end
    end

    // gpsdo status survives a bus reset
    always_ff @(posedge bus_clk) begin
        if (i_set_stb && i_set_addr == `SR_CORE_GPSDO_ST) begin
            gpsdo_st <= i_set_data[7:0];
        end
    end

    // lock bits come from the frontend
    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            lock_meta <= 2'd0;
            lock_sync <= 2'd0;
        end else begin
            lock_meta <= i_lock_signals;
            lock_sync <= lock_meta;
        end
    end

    assign o_misc_outs  = misc_q;
    assign o_time_sync  = sync_q[2];
    assign o_pps_select = sync_q[1:0];

    // readback
    always_comb begin
        case (rb_sel)
            RB_COMPAT: o_readback = {`CORE_MAGIC, `COMPAT_MAJOR, `COMPAT_MINOR};
            // no SPI core in this build
            RB_SPI:    o_readback = '0;
            RB_STATUS: o_readback = {16'd0, `RADIO_STATUS, gpsdo_st, i_rb_misc};
            RB_LOCK:   o_readback = {62'd0, lock_sync};
            default:   o_readback = '0;
        endcase
    end
endmodule

// ==== logic/b200_ctrl_core.sv ====
// b200 core control path top
// SID demux, core processor and settings,
// empty radio slot loopback, response merge

`timescale 1ns/1ns
`include "b200_core_settings.svh"

module b200_ctrl_core (
    input  logic                   bus_clk,
    input  logic                   bus_rst,
    input  logic [`CTRL_WIDTH-1:0] i_ctrl_tdata,
    input  logic                   i_ctrl_tlast,
    input  logic                   i_ctrl_tvalid,
    output logic                   o_ctrl_tready,
    output logic [`CTRL_WIDTH-1:0] o_resp_tdata,
    output logic                   o_resp_tlast,
    output logic                   o_resp_tvalid,
    input  logic                   i_resp_tready,
    input  logic [31:0]            i_rb_misc,
    input  logic [1:0]             i_lock_signals,
    output logic [31:0]            o_misc_outs,
    output logic [1:0]             o_pps_select,
    output logic                   o_time_sync
);
    logic                   set_stb;
    logic [7:0]             set_addr;
    logic [31:0]            set_data;
    logic [`CTRL_WIDTH-1:0] readback;

    cvita_stream_if ctrl_in ();
    cvita_stream_if ctrl_to_proc ();
    cvita_stream_if ctrl_to_loop ();
    cvita_stream_if proc_resp ();
    cvita_stream_if loop_resp ();
    cvita_stream_if resp_out ();

    // external ports onto the streams
    assign ctrl_in.tdata   = i_ctrl_tdata;
    assign ctrl_in.tlast   = i_ctrl_tlast;
    assign ctrl_in.tvalid  = i_ctrl_tvalid;
    assign o_ctrl_tready   = ctrl_in.tready;

    assign o_resp_tdata    = resp_out.tdata;
    assign o_resp_tlast    = resp_out.tlast;
    assign o_resp_tvalid   = resp_out.tvalid;
    assign resp_out.tready = i_resp_tready;

    sid_ctrl_demux u_demux (
        .bus_clk (bus_clk),
        .bus_rst (bus_rst),
        .i_ctrl  (ctrl_in),
        .o_local (ctrl_to_proc),
        .o_loop  (ctrl_to_loop)
    );

    ////////////////////
    // core control
    ////////////////////
    core_ctrl_proc u_proc (
        .bus_clk    (bus_clk),
        .bus_rst    (bus_rst),
        .i_ctrl     (ctrl_to_proc),
        .o_resp     (proc_resp),
        .o_set_stb  (set_stb),
        .o_set_addr (set_addr),
        .o_set_data (set_data),
        .i_readback (readback)
    );

    core_settings u_settings (
        .bus_clk        (bus_clk),
        .bus_rst        (bus_rst),
        .i_set_stb      (set_stb),
        .i_set_addr     (set_addr),
        .i_set_data     (set_data),
        .i_rb_misc      (i_rb_misc),
        .i_lock_signals (i_lock_signals),
        .o_misc_outs    (o_misc_outs),
        .o_pps_select   (o_pps_select),
        .o_time_sync    (o_time_sync),
        .o_readback     (readback)
    );

    // second radio slot is empty, echo its control traffic
    assign loop_resp.tdata     = ctrl_to_loop.tdata;
    assign loop_resp.tlast     = ctrl_to_loop.tlast;
    assign loop_resp.tvalid    = ctrl_to_loop.tvalid;
    assign ctrl_to_loop.tready = loop_resp.tready;

    ctrl_resp_mux u_mux (
        .bus_clk (bus_clk),
        .bus_rst (bus_rst),
        .i_proc  (proc_resp),
        .i_loop  (loop_resp),
        .o_resp  (resp_out)
    );
endmodule

// ==== verification/tb_b200_ctrl_core.sv ====
// testbench for the b200 control path top
// clock, reset, packet stimulus on the falling edge
// reference model, response monitor and watchdog

`timescale 1ns/1ns
`include "b200_core_settings.svh"

module tb_b200_ctrl_core;
    import b200_core_pkg::*;

    localparam int NUM_TESTS = 6;

    logic        bus_clk;
    logic        bus_rst;
    logic [63:0] i_ctrl_tdata;
    logic        i_ctrl_tlast;
    logic        i_ctrl_tvalid;
    logic        o_ctrl_tready;
    logic [63:0] o_resp_tdata;
    logic        o_resp_tlast;
    logic        o_resp_tvalid;
    logic        i_resp_tready;
    logic [31:0] i_rb_misc;
    logic [1:0]  i_lock_signals;
    logic [31:0] o_misc_outs;
    logic [1:0]  o_pps_select;
    logic        o_time_sync;

    integer      seed = 67;
    string       test_name;
    logic [15:0] seq_num;
    logic        ready_rand;
    logic [31:0] rnd;
    logic [31:0] rnd_rdy;

    // model of the core registers
    logic [31:0] misc_m;
    rb_sel_t     rb_sel_m;
    logic [7:0]  gpsdo_m;
    logic [2:0]  sync_m;
    logic [31:0] rb_misc_m;
    logic [1:0]  lock_m;

    // expected responses with one queue per source
    logic [63:0] proc_q[$];
    logic [63:0] loop_q[$];
    bit          loop_last_q[$];
    logic        in_resp;
    logic        cur_loop;
    int          beat;

    b200_ctrl_core u_dut (.*);

    initial begin
        bus_clk = 1'b0;
        forever #50 bus_clk = ~bus_clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    ////////////////////
    // compare tasks
    ////////////////////
    task automatic compare_hdr(input string what, input ctrl_hdr_t exp, input ctrl_hdr_t act);
        if (act !== exp) begin
            fail_now($sformatf("mismatch in %s (%s): expected %h, actual %h",
                test_name, what, exp, act));
        end
    endtask

    task automatic compare_word(input string what, input logic [63:0] exp,
            input logic [63:0] act);
        if (act !== exp) begin
            fail_now($sformatf("mismatch in %s (%s): expected %h, actual %h",
                test_name, what, exp, act));
        end
    endtask

    task automatic compare_reg(input string what, input logic [31:0] exp,
            input logic [31:0] act);
        if (act !== exp) begin
            fail_now($sformatf("mismatch in %s (%s): expected %h, actual %h",
                test_name, what, exp, act));
        end
    endtask

    // predicts one local response and updates the model
    function automatic void predict_response(input ctrl_hdr_t hdr, input ctrl_cmd_t cmd,
            output ctrl_hdr_t exp_hdr, output logic [63:0] exp_rb);
        exp_hdr.seqnum  = hdr.seqnum;
        exp_hdr.pkt_len = 16'd16;
        exp_hdr.src_sid = hdr.dst_sid;
        exp_hdr.dst_sid = hdr.src_sid;
        case (cmd.set_addr)
            `SR_CORE_MISC:     misc_m = cmd.set_data;
            `SR_CORE_READBACK: rb_sel_m = rb_sel_t'(cmd.set_data[1:0]);
            `SR_CORE_GPSDO_ST: gpsdo_m = cmd.set_data[7:0];
            `SR_CORE_SYNC:     sync_m = cmd.set_data[2:0];
            default:           ;
        endcase
        case (rb_sel_m)
            RB_COMPAT: exp_rb = 64'hACE0BA5E_0010_0000;
            RB_SPI:    exp_rb = 64'd0;
            RB_STATUS: exp_rb = {16'd0, 8'd1, gpsdo_m, rb_misc_m};
            default:   exp_rb = {62'd0, lock_m};
        endcase
    endfunction

    ////////////////////
    // stimulus
    ////////////////////
    // present one word and hold it until the DUT is ready
    task automatic drive_word(input logic [63:0] data, input logic last);
        @(negedge bus_clk);
        i_ctrl_tdata  = data;
        i_ctrl_tlast  = last;
        i_ctrl_tvalid = 1'b1;
        #1;
        while (!o_ctrl_tready) begin
            @(negedge bus_clk);
            #1;
        end
    endtask

    task automatic end_packet();
        @(negedge bus_clk);
        i_ctrl_tvalid = 1'b0;
        i_ctrl_tlast  = 1'b0;
    endtask

    task automatic send_local(input logic [7:0] dst_low, input logic [7:0] addr,
            input logic [31:0] data, input int extra);
        ctrl_word_u  hdr_w;
        ctrl_word_u  cmd_w;
        ctrl_hdr_t   exp_hdr;
        logic [63:0] exp_rb;
        hdr_w.hdr.seqnum   = seq_num;
        hdr_w.hdr.pkt_len  = 16'((2 + extra) * 8);
        hdr_w.hdr.src_sid  = 16'h0011;
        hdr_w.hdr.dst_sid  = {8'h00, dst_low};
        cmd_w.cmd.reserved = 24'd0;
        cmd_w.cmd.set_addr = addr;
        cmd_w.cmd.set_data = data;
        seq_num = seq_num + 16'd1;
        predict_response(hdr_w.hdr, cmd_w.cmd, exp_hdr, exp_rb);
        proc_q.push_back(exp_hdr);
        proc_q.push_back(exp_rb);
        drive_word(hdr_w, 1'b0);
        drive_word(cmd_w, extra == 0);
        for (int i = 0; i < extra; i++) begin
            drive_word({$random(seed), $random(seed)}, i == extra - 1);
        end
        end_packet();
    endtask

    // packet for the empty slot that is echoed back as is
    task automatic send_loop(input int nwords);
        ctrl_word_u  hdr_w;
        logic [63:0] w;
        rnd = $random(seed);
        hdr_w.hdr.seqnum  = rnd[31:16];
        hdr_w.hdr.pkt_len = 16'(nwords * 8);
        hdr_w.hdr.src_sid = 16'h0030;
        hdr_w.hdr.dst_sid = {8'h00, 4'h2, rnd[3:0]};
        for (int i = 0; i < nwords; i++) begin
            w = (i == 0) ? hdr_w : {$random(seed), $random(seed)};
            loop_q.push_back(w);
            loop_last_q.push_back(i == nwords - 1);
            drive_word(w, i == nwords - 1);
        end
        end_packet();
    endtask

    task automatic wait_idle();
        while (proc_q.size() != 0 || loop_q.size() != 0) begin
            @(negedge bus_clk);
        end
        repeat (3) @(negedge bus_clk);
    endtask

    task automatic check_outs();
        compare_reg("misc_outs", misc_m, o_misc_outs);
        compare_reg("time_sync and pps_select", {29'd0, sync_m},
            {29'd0, o_time_sync, o_pps_select});
    endtask

    ////////////////////
    // response monitor
    ////////////////////
    task automatic check_resp_word();
        logic exp_last;
        if (!in_resp) begin
            cur_loop = ((o_resp_tdata[7:0] & `DEMUX_SID_MASK) == `R1_CTRL_SID);
            beat     = 0;
            in_resp  = 1'b1;
        end
        if (cur_loop) begin
            if (loop_q.size() == 0) begin
                fail_now("a loopback response word arrived when none was expected");
            end
            exp_last = loop_last_q.pop_front();
            compare_word("loopback echo", loop_q.pop_front(), o_resp_tdata);
        end else begin
            if (proc_q.size() == 0) begin
                fail_now("a processor response word arrived when none was expected");
            end
            exp_last = (beat == 1);
            if (beat == 0) begin
                compare_hdr("response header", proc_q.pop_front(), o_resp_tdata);
            end else begin
                compare_word("readback", proc_q.pop_front(), o_resp_tdata);
            end
        end
        if (o_resp_tlast !== exp_last) begin
            fail_now("response packet has tlast on the wrong word");
        end
        beat = beat + 1;
        if (o_resp_tlast) begin
            in_resp = 1'b0;
        end
    endtask

    // sample just before the rising edge when inputs and outputs have settled
    initial begin
        in_resp  = 1'b0;
        cur_loop = 1'b0;
        beat     = 0;
        forever begin
            @(negedge bus_clk);
            #45;
            if (o_resp_tvalid && i_resp_tready) begin
                check_resp_word();
            end
        end
    end

    // ready value drawn at the rising edge, driven at the falling edge
    initial begin
        forever begin
            @(posedge bus_clk);
            if (ready_rand) begin
                rnd_rdy = $random(seed);
            end else begin
                rnd_rdy = 32'd1;
            end
            @(negedge bus_clk);
            i_resp_tready = rnd_rdy[0];
        end
    end

    initial begin
        repeat (NUM_TESTS * 2000) @(posedge bus_clk);
        fail_now("watchdog timeout, the tests did not finish in time");
    end

    ////////////////////
    // test sequence
    ////////////////////
    initial begin
        bus_rst        = 1'b1;
        i_ctrl_tdata   = 64'd0;
        i_ctrl_tlast   = 1'b0;
        i_ctrl_tvalid  = 1'b0;
        i_resp_tready  = 1'b1;
        i_rb_misc      = 32'd0;
        i_lock_signals = 2'd0;
        ready_rand     = 1'b0;
        seq_num        = 16'h0100;
        misc_m         = 32'd0;
        rb_sel_m       = RB_COMPAT;
        gpsdo_m        = 8'd0;
        sync_m         = 3'd0;
        rb_misc_m      = 32'd0;
        lock_m         = 2'd0;
        test_name      = "reset";
        repeat (8) @(posedge bus_clk);
        @(negedge bus_clk);
        bus_rst = 1'b0;

        test_name = "compat readback";
        send_local(`L0_CTRL_SID, `SR_CORE_READBACK, 32'd0, 0);
        send_local(`L0_CTRL_SID, `SR_CORE_READBACK, 32'd0, 2);
        wait_idle();

        test_name = "register writes";
        send_local(`L0_CTRL_SID, `SR_CORE_MISC, $random(seed), 0);
        send_local(`L0_CTRL_SID, `SR_CORE_SYNC, $random(seed), 0);
        wait_idle();
        check_outs();
        send_local(`L0_CTRL_SID, 8'd99, $random(seed), 0);
        wait_idle();
        check_outs();

        test_name = "status, spi and lock readback";
        rnd = $random(seed);
        i_rb_misc      = rnd;
        rb_misc_m      = rnd;
        i_lock_signals = 2'b10;
        lock_m         = 2'b10;
        send_local(`L0_CTRL_SID, `SR_CORE_GPSDO_ST, $random(seed), 0);
        send_local(`L0_CTRL_SID, `SR_CORE_READBACK, 32'd2, 0);
        send_local(`L0_CTRL_SID, `SR_CORE_READBACK, 32'd1, 0);
        send_local(`L0_CTRL_SID, `SR_CORE_READBACK, 32'd3, 0);
        wait_idle();
        i_lock_signals = 2'b01;
        lock_m         = 2'b01;
        repeat (4) @(negedge bus_clk);
        send_local(`L0_CTRL_SID, 8'd99, 32'd0, 0);
        wait_idle();

        test_name = "sid routing";
        send_loop(3);
        send_loop(1);
        send_local(8'h45, `SR_CORE_READBACK, 32'd0, 0);
        send_local(8'h77, `SR_CORE_MISC, $random(seed), 1);
        send_local(8'h00, 8'd99, 32'd0, 0);
        wait_idle();

        test_name = "interleaved traffic with back-pressure";
        ready_rand = 1'b1;
        for (int n = 0; n < 16; n++) begin
            rnd = $random(seed);
            if (rnd[0]) begin
                send_loop(1 + int'(rnd[2:1]));
            end else begin
                send_local(`L0_CTRL_SID, `SR_CORE_MISC, $random(seed), rnd[3] ? 1 : 0);
            end
        end
        wait_idle();
        ready_rand = 1'b0;
        check_outs();

        test_name = "header-only packet";
        drive_word({16'h0bad, 16'd8, 16'h0011, 16'h0040}, 1'b1);
        end_packet();
        repeat (10) @(negedge bus_clk);
        send_local(`L0_CTRL_SID, `SR_CORE_READBACK, 32'd0, 0);
        wait_idle();

        $display("Test completed successfully");
        $finish;
    end
endmodule

// ==== sources.f ====
+incdir+common
common/b200_core_pkg.sv
common/cvita_stream_if.sv
routing/sid_ctrl_demux.sv
routing/ctrl_resp_mux.sv
logic/core_ctrl_proc.sv
logic/core_settings.sv
logic/b200_ctrl_core.sv
verification/tb_b200_ctrl_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the control path testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f sources.f \
    --top-module tb_b200_ctrl_core -o tb_b200_ctrl_core
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_b200_ctrl_core
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished with status 0"
exit 0
